//--- fabric_tag_xlate_top.f
rtl/fabric_pkg.sv
rtl/fabric_stream_buffer.sv
rtl/fabric_map_table.sv
rtl/fabric_map_tag.sv
rtl/fabric_tag_demux.sv
rtl/fabric_tag_xlate_top.sv
bench/fabric_xlate_checker.sv
bench/tb_fabric_tag_xlate.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_fabric_tag_xlate
RTL_TOP    := fabric_tag_xlate_top
FILELIST   := fabric_tag_xlate_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_fabric_tag_xlate.sv
`timescale 1ns/100ps

module tb_fabric_tag_xlate;

  import fabric_pkg::*;

  // Upper bound for any single wait loop
  localparam int TIMEOUT_CYCLES = 4000;

  logic                             clk;
  logic                             rst_n;
  logic                             in_valid;
  logic                             in_ready;
  in_item_t                         in_item;
  logic                             cfg_we;
  logic [TABLE_IDX_W-1:0]           cfg_index;
  map_entry_t                       cfg_entry;
  logic [NUM_LANES-1:0]             lane_valid;
  logic [NUM_LANES-1:0]             lane_ready;
  logic [NUM_LANES-1:0][DATA_W-1:0] lane_value;
  logic                             error_valid;
  logic [ERR_W-1:0]                 error_code;
  logic                             idle_check;
  int                               error_count;
  int                               delivered_count;
  int                               dropped_count;
  int                               pending_count;
  logic [31:0]                      rng;
  logic                             timed_out;
  // Source tags loaded in the table, used only to pick stimulus
  logic [IN_TAG_W-1:0]              live_tags [TABLE_SIZE];

  // --------------------------------------------------
  // Clock, DUT and checker
  // --------------------------------------------------

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  fabric_tag_xlate_top fabric_tag_xlate_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_item     (in_item),
    .cfg_we      (cfg_we),
    .cfg_index   (cfg_index),
    .cfg_entry   (cfg_entry),
    .lane_valid  (lane_valid),
    .lane_ready  (lane_ready),
    .lane_value  (lane_value),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

  fabric_xlate_checker checker_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .in_item         (in_item),
    .cfg_we          (cfg_we),
    .cfg_index       (cfg_index),
    .cfg_entry       (cfg_entry),
    .lane_valid      (lane_valid),
    .lane_ready      (lane_ready),
    .lane_value      (lane_value),
    .error_valid     (error_valid),
    .error_code      (error_code),
    .idle_check      (idle_check),
    .error_count     (error_count),
    .delivered_count (delivered_count),
    .dropped_count   (dropped_count),
    .pending_count   (pending_count)
  );

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reset held for 10 cycles, then wait for the buffers to accept
  task automatic apply_reset();
    int guard;
    guard = 0;
    @(posedge clk);
    rst_n      <= 1'b0;
    in_valid   <= 1'b0;
    cfg_we     <= 1'b0;
    lane_ready <= '0;
    idle_check <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    while (!in_ready && !timed_out) begin
      guard++;
      if (guard > 20) begin
        $display("Timeout: in_ready never rose after reset");
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
      end
    end
  endtask

  // One table entry per strobe
  task automatic write_entry(input int idx, input int v, input int src, input int dst);
    map_entry_t e;
    e.valid   = (v != 0);
    e.src_tag = IN_TAG_W'(src);
    e.dst_tag = OUT_TAG_W'(dst);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_index <= TABLE_IDX_W'(idx);
    cfg_entry <= e;
    live_tags[idx] = e.src_tag;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  // Random items with random gaps and random lane stalls
  task automatic stream_items(input int n, input bit with_misses);
    int          offered;
    int          taken;
    int          guard;
    logic [31:0] r;
    in_item_t    it;
    if (timed_out) return;
    offered = 0;
    taken   = 0;
    guard   = 0;
    while (taken < n && !timed_out) begin
      @(posedge clk);
      rng = xorshift32(rng);
      r   = rng;
      // About three cycles in four ready per lane
      lane_ready <= r[3:0] | r[7:4];
      if (in_valid && in_ready) begin
        taken++;
      end
      // Payload only changes once the offer is taken
      if (!in_valid || in_ready) begin
        if (offered < n && r[9:8] != 2'b00) begin
          rng = xorshift32(rng);
          it.value = rng;
          if (with_misses && r[14:12] == 3'd0) begin
            // Tag 5 is never loaded
            it.tag = 4'd5;
          end else begin
            it.tag = live_tags[r[11:10]];
          end
          in_valid <= 1'b1;
          in_item  <= it;
          offered++;
        end else begin
          in_valid <= 1'b0;
        end
      end
      guard++;
      if (guard > TIMEOUT_CYCLES) begin
        $display("Timeout: input stalled after %0d of %0d items", taken, n);
        timed_out = 1'b1;
      end
    end
  endtask

  // Empty all lanes, then let the checker compare the idle state
  task automatic drain_and_check();
    int guard;
    if (timed_out) return;
    guard = 0;
    @(posedge clk);
    in_valid   <= 1'b0;
    lane_ready <= '1;
    while (pending_count != 0 && !timed_out) begin
      @(posedge clk);
      guard++;
      if (guard > TIMEOUT_CYCLES) begin
        $display("Timeout: %0d items still pending on the lanes", pending_count);
        timed_out = 1'b1;
      end
    end
    // Dropped items leave within the two-cycle pipeline
    repeat (4) @(posedge clk);
    idle_check <= 1'b1;
    @(posedge clk);
    idle_check <= 1'b0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    rng        = 32'h31188b0b;
    timed_out  = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_item    = '0;
    cfg_we     = 1'b0;
    cfg_index  = '0;
    cfg_entry  = '0;
    lane_ready = '0;
    idle_check = 1'b0;
    for (int i = 0; i < TABLE_SIZE; i++) begin
      live_tags[i] = '0;
    end

    // Reset state, nothing latched
    apply_reset();
    drain_and_check();

    // Distinct tags spread over all four lanes
    write_entry(0, 1, 3, 2);
    write_entry(1, 1, 7, 0);
    write_entry(2, 1, 10, 3);
    write_entry(3, 1, 12, 1);
    stream_items(300, 1'b0);
    drain_and_check();

    // Tag 7 moves from lane 0 to lane 3
    write_entry(1, 1, 7, 3);
    stream_items(200, 1'b0);
    drain_and_check();

    // Unknown tags mixed in, later traffic keeps flowing
    stream_items(200, 1'b1);
    drain_and_check();

    // Fresh reset, tag 9 loaded twice
    apply_reset();
    write_entry(0, 1, 9, 1);
    write_entry(1, 1, 9, 3);
    write_entry(2, 1, 4, 2);
    write_entry(3, 1, 11, 0);
    stream_items(200, 1'b0);
    drain_and_check();

    $display("Summary: %0d delivered, %0d dropped, %0d errors, timeout %0d",
             delivered_count, dropped_count, error_count, timed_out);
    if (timed_out || error_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

//--- bench/fabric_xlate_checker.sv
`timescale 1ns/100ps

module fabric_xlate_checker (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   in_valid,
  input  logic                                                   in_ready,
  input  fabric_pkg::in_item_t                                   in_item,
  input  logic                                                   cfg_we,
  input  logic [fabric_pkg::TABLE_IDX_W-1:0]                    cfg_index,
  input  fabric_pkg::map_entry_t                                 cfg_entry,
  input  logic [fabric_pkg::NUM_LANES-1:0]                      lane_valid,
  input  logic [fabric_pkg::NUM_LANES-1:0]                      lane_ready,
  input  logic [fabric_pkg::NUM_LANES-1:0][fabric_pkg::DATA_W-1:0] lane_value,
  input  logic                                                   error_valid,
  input  logic [fabric_pkg::ERR_W-1:0]                          error_code,
  input  logic                                                   idle_check,
  output int                                                     error_count,
  output int                                                     delivered_count,
  output int                                                     dropped_count,
  output int                                                     pending_count
);

  import fabric_pkg::*;

  // Shadow of the table, written from the cfg port
  map_entry_t        model_tbl [TABLE_SIZE];
  // Expected values per lane, oldest first
  logic [DATA_W-1:0] exp_q [NUM_LANES][$];
  logic              exp_err_valid;
  logic [ERR_W-1:0]  exp_err_code;
  logic              err_seen;
  // Reset level seen on the previous edge
  logic              rst_d = 1'b1;
  int                errors = 0;
  int                reset_errors = 0;
  int                delivered = 0;
  int                dropped = 0;

  assign error_count     = errors + reset_errors;
  assign delivered_count = delivered;
  assign dropped_count   = dropped;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Lowest valid index wins, -1 when nothing matches
  function automatic int lookup_lane(input logic [IN_TAG_W-1:0] tag);
    int lane;
    lane = -1;
    for (int i = 0; i < TABLE_SIZE; i++) begin
      if (lane < 0 && model_tbl[i].valid && model_tbl[i].src_tag == tag) begin
        lane = int'(model_tbl[i].dst_tag);
      end
    end
    return lane;
  endfunction

  // Any two valid entries sharing a source tag
  function automatic logic table_has_dup();
    logic dup;
    dup = 1'b0;
    for (int i = 0; i < TABLE_SIZE; i++) begin
      for (int j = 0; j < TABLE_SIZE; j++) begin
        if (i != j && model_tbl[i].valid && model_tbl[j].valid &&
            model_tbl[i].src_tag == model_tbl[j].src_tag) begin
          dup = 1'b1;
        end
      end
    end
    return dup;
  endfunction

  // --------------------------------------------------
  // Reset state of the outputs
  // --------------------------------------------------

  always @(posedge clk) begin
    rst_d <= rst_n;
    // Outputs judged only once reset was already low on the edge before
    if (!rst_n && !rst_d) begin
      if (lane_valid !== '0) begin
        $display("[FAIL] %0t lane_valid: expected 0, got %b", $time, lane_valid);
        reset_errors++;
      end
      if (error_valid !== 1'b0) begin
        $display("[FAIL] %0t error_valid: expected 0, got %b", $time, error_valid);
        reset_errors++;
      end
      if (in_ready !== 1'b0) begin
        $display("[FAIL] %0t in_ready: expected 0, got %b", $time, in_ready);
        reset_errors++;
      end
    end
  end

  // --------------------------------------------------
  // Traffic and error watch
  // --------------------------------------------------

  always @(posedge clk or negedge rst_n) begin : watch
    int                lane;
    int                total;
    logic [DATA_W-1:0] exp_val;
    if (!rst_n) begin
      for (int i = 0; i < TABLE_SIZE; i++) begin
        model_tbl[i] = '0;
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        exp_q[l].delete();
      end
      exp_err_valid = 1'b0;
      exp_err_code  = ERR_NONE;
      err_seen      = 1'b0;
      pending_count <= 0;
    end else begin
      // Table write seen on this edge
      if (cfg_we) begin
        model_tbl[cfg_index] = cfg_entry;
      end
      // Duplicate tags outrank a miss
      if (!exp_err_valid && table_has_dup()) begin
        exp_err_valid = 1'b1;
        exp_err_code  = CFG_MAP_TAG_DUP_TAG;
      end
      // Input transfer
      if (in_valid && in_ready) begin
        lane = lookup_lane(in_item.tag);
        if (lane >= 0) begin
          exp_q[lane].push_back(in_item.value);
        end else begin
          dropped++;
          if (!exp_err_valid) begin
            exp_err_valid = 1'b1;
            exp_err_code  = RT_MAP_TAG_NO_MATCH;
          end
        end
      end
      // Lane transfers, in order per lane
      for (int l = 0; l < NUM_LANES; l++) begin
        if (lane_valid[l] && lane_ready[l]) begin
          if (exp_q[l].size() == 0) begin
            $display("%0t: lane %0d delivered %h with no item expected",
                     $time, l, lane_value[l]);
            errors++;
          end else begin
            exp_val = exp_q[l].pop_front();
            delivered++;
            if (lane_value[l] !== exp_val) begin
              $display("[FAIL] %0t lane_value[%0d]: expected %h, got %h",
                       $time, l, exp_val, lane_value[l]);
              errors++;
            end
          end
        end
      end
      // Rising edge of the error flag
      if (error_valid && !err_seen) begin
        if (!exp_err_valid) begin
          $display("%0t: error_valid rose with no error expected", $time);
          errors++;
        end else if (error_code !== exp_err_code) begin
          $display("[FAIL] %0t error_code: expected %h, got %h",
                   $time, exp_err_code, error_code);
          errors++;
        end
      end
      if (err_seen && !error_valid) begin
        $display("%0t: error_valid fell without a reset", $time);
        errors++;
      end
      err_seen = error_valid;
      total = 0;
      for (int l = 0; l < NUM_LANES; l++) begin
        total += exp_q[l].size();
      end
      // Pipeline idle, so the error state must have settled
      if (idle_check) begin
        if (error_valid !== exp_err_valid) begin
          $display("[FAIL] %0t error_valid: expected %b, got %b",
                   $time, exp_err_valid, error_valid);
          errors++;
        end else if (error_valid && error_code !== exp_err_code) begin
          $display("[FAIL] %0t error_code: expected %h, got %h",
                   $time, exp_err_code, error_code);
          errors++;
        end
        if (total != 0) begin
          $display("%0t: %0d expected items never reached their lane", $time, total);
          errors++;
        end
      end
      pending_count <= total;
    end
  end

endmodule

//--- rtl/fabric_tag_xlate_top.sv
`timescale 1ns/100ps

module fabric_tag_xlate_top (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   in_valid,
  output logic                                                   in_ready,
  input  fabric_pkg::in_item_t                                   in_item,
  input  logic                                                   cfg_we,
  input  logic [fabric_pkg::TABLE_IDX_W-1:0]                    cfg_index,
  input  fabric_pkg::map_entry_t                                 cfg_entry,
  output logic [fabric_pkg::NUM_LANES-1:0]                      lane_valid,
  input  logic [fabric_pkg::NUM_LANES-1:0]                      lane_ready,
  output logic [fabric_pkg::NUM_LANES-1:0][fabric_pkg::DATA_W-1:0] lane_value,
  output logic                                                   error_valid,
  output logic [fabric_pkg::ERR_W-1:0]                          error_code
);

  import fabric_pkg::*;

  // Input buffer to mapper
  logic       ib_valid;
  logic       ib_ready;
  in_item_t   ib_item;

  // Mapper to output buffer
  logic       mt_valid;
  logic       mt_ready;
  out_item_t  mt_item;

  // Output buffer to demux
  logic       ob_valid;
  logic       ob_ready;
  out_item_t  ob_item;

  // Live table contents
  map_table_t table_q;

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------

  fabric_stream_buffer #(.T(in_item_t)) in_buf_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_payload  (in_item),
    .out_valid   (ib_valid),
    .out_ready   (ib_ready),
    .out_payload (ib_item)
  );

  fabric_map_tag map_tag_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (ib_valid),
    .in_ready    (ib_ready),
    .in_item     (ib_item),
    .out_valid   (mt_valid),
    .out_ready   (mt_ready),
    .out_item    (mt_item),
    .table_q     (table_q),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

  fabric_stream_buffer #(.T(out_item_t)) out_buf_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (mt_valid),
    .in_ready    (mt_ready),
    .in_payload  (mt_item),
    .out_valid   (ob_valid),
    .out_ready   (ob_ready),
    .out_payload (ob_item)
  );

  fabric_tag_demux demux_i (
    .in_valid   (ob_valid),
    .in_ready   (ob_ready),
    .in_item    (ob_item),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .lane_value (lane_value)
  );

  // --------------------------------------------------
  // Configuration
  // --------------------------------------------------

  fabric_map_table map_table_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_index (cfg_index),
    .cfg_entry (cfg_entry),
    .table_q   (table_q)
  );

endmodule

//--- rtl/fabric_tag_demux.sv
`timescale 1ns/100ps

module fabric_tag_demux (
  input  logic                                                   in_valid,
  output logic                                                   in_ready,
  input  fabric_pkg::out_item_t                                  in_item,
  output logic [fabric_pkg::NUM_LANES-1:0]                      lane_valid,
  input  logic [fabric_pkg::NUM_LANES-1:0]                      lane_ready,
  output logic [fabric_pkg::NUM_LANES-1:0][fabric_pkg::DATA_W-1:0] lane_value
);

  import fabric_pkg::*;

  // One-hot lane select from the destination tag
  logic [NUM_LANES-1:0] lane_sel;

  // --------------------------------------------------
  // Lane decode
  // --------------------------------------------------

  always_comb begin
    lane_sel = '0;
    lane_sel[in_item.tag] = 1'b1;
  end

  // Valid reaches the selected lane only
  assign lane_valid = in_valid ? lane_sel : '0;

  // --------------------------------------------------
  // Back-pressure
  // --------------------------------------------------

  // Upstream waits on the target lane alone
  // other lanes stalling have no effect on this item
  assign in_ready = |(lane_ready & lane_sel);

  // --------------------------------------------------
  // Value fan-out
  // --------------------------------------------------

  // Every lane sees the same value
  // lane_valid says which one should take it
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_value[i] = in_item.value;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // At most one lane offered an item at a time
  always_comb begin
    assert ($onehot0(lane_valid));
  end

endmodule

//--- rtl/fabric_map_tag.sv
`timescale 1ns/100ps

module fabric_map_tag (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  fabric_pkg::in_item_t          in_item,
  output logic                          out_valid,
  input  logic                          out_ready,
  output fabric_pkg::out_item_t         out_item,
  input  fabric_pkg::map_table_t        table_q,
  output logic                          error_valid,
  output logic [fabric_pkg::ERR_W-1:0] error_code
);

  import fabric_pkg::*;

  logic [TABLE_SIZE-1:0] match_vec;
  logic                  match_found;
  logic [OUT_TAG_W-1:0]  matched_dst_tag;
  logic                  cfg_dup_tag;
  logic                  rt_no_match;

  // --------------------------------------------------
  // CAM compare
  // --------------------------------------------------

  // Only valid entries take part in the lookup
  always_comb begin
    for (int i = 0; i < TABLE_SIZE; i++) begin
      match_vec[i] = table_q[i].valid && (table_q[i].src_tag == in_item.tag);
    end
  end

  assign match_found = |match_vec;

  // Priority select
  // Scan from the top so the lowest matching index is written last
  always_comb begin
    matched_dst_tag = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        matched_dst_tag = table_q[i].dst_tag;
      end
    end
  end

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------

  // Value passes untouched, only the tag is swapped
  assign out_item.value = in_item.value;
  assign out_item.tag   = matched_dst_tag;

  // Unmatched items never show valid downstream
  assign out_valid = in_valid && match_found;

  // Ready passes straight through
  // an unmatched item is dropped once downstream is ready
  assign in_ready = out_ready;

  // --------------------------------------------------
  // Error detection
  // --------------------------------------------------

  // Pairwise scan for two valid entries with one source tag
  always_comb begin
    cfg_dup_tag = 1'b0;
    for (int i = 0; i < TABLE_SIZE; i++) begin
      for (int j = i + 1; j < TABLE_SIZE; j++) begin
        if (table_q[i].valid && table_q[j].valid &&
            (table_q[i].src_tag == table_q[j].src_tag)) begin
          cfg_dup_tag = 1'b1;
        end
      end
    end
  end

  // Valid input with nowhere to go
  assign rt_no_match = in_valid && !match_found;

  // First error wins and sticks until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= ERR_NONE;
    end else if (!error_valid) begin
      // Table fault ranks above a runtime miss
      if (cfg_dup_tag) begin
        error_valid <= 1'b1;
        error_code  <= CFG_MAP_TAG_DUP_TAG;
      end else if (rt_no_match) begin
        error_valid <= 1'b1;
        error_code  <= RT_MAP_TAG_NO_MATCH;
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Latched error only clears through reset
  assert property (@(posedge clk) disable iff (!rst_n)
    error_valid |=> (error_valid && $stable(error_code)));

endmodule

//--- rtl/fabric_map_table.sv
`timescale 1ns/100ps

module fabric_map_table (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cfg_we,
  input  logic [fabric_pkg::TABLE_IDX_W-1:0] cfg_index,
  input  fabric_pkg::map_entry_t              cfg_entry,
  output fabric_pkg::map_table_t              table_q
);

  import fabric_pkg::*;

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------

  // One enable per entry
  logic [TABLE_SIZE-1:0] entry_we;

  always_comb begin
    entry_we = '0;
    if (cfg_we) begin
      entry_we[cfg_index] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Entry registers
  // --------------------------------------------------

  // Every entry comes up invalid so no tag maps before software loads it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < TABLE_SIZE; i++) begin
        table_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < TABLE_SIZE; i++) begin
        // Whole entry replaced at once
        if (entry_we[i]) begin
          table_q[i] <= cfg_entry;
        end
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Unknown index would corrupt an arbitrary entry
  assert property (@(posedge clk) disable iff (!rst_n)
    cfg_we |-> !$isunknown(cfg_index));

endmodule

//--- rtl/fabric_stream_buffer.sv
`timescale 1ns/100ps

module fabric_stream_buffer #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_payload,
  output logic out_valid,
  input  logic out_ready,
  output T     out_payload
);

  // Two payload slots used as a tiny circular FIFO
  T           slot_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_d;
  logic       ready_q;
  logic       push;
  logic       pop;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------

  // Ready comes from a flop so upstream never sees the downstream ready path
  assign in_ready    = ready_q;
  assign push        = in_valid && ready_q;
  assign out_valid   = (count_q != 2'd0);
  assign pop         = out_valid && out_ready;
  assign out_payload = slot_q[rd_ptr_q];

  // Fill level for the next cycle
  always_comb begin
    case ({push, pop})
      2'b10:   count_d = count_q + 2'd1;
      2'b01:   count_d = count_q - 2'd1;
      default: count_d = count_q;
    endcase
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      // Held low until the first edge out of reset
      ready_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_d;
      ready_q <= (count_d != 2'd2);
    end
  end

  // Payload slots
  always_ff @(posedge clk) begin
    if (push) begin
      slot_q[wr_ptr_q] <= in_payload;
    end
  end

  // Registered ready must keep writes out of a full buffer
  assert property (@(posedge clk) disable iff (!rst_n)
    (count_q == 2'd2) |-> !push);

endmodule

//--- rtl/fabric_pkg.sv
package fabric_pkg;

  // --------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------

  // Value carried by every stream item
  localparam int DATA_W = 32;

  // Source tag on the input side
  localparam int IN_TAG_W = 4;

  // Destination tag after translation
  localparam int OUT_TAG_W = 2;

  // Number of CAM entries in the map table
  localparam int TABLE_SIZE = 4;
  localparam int TABLE_IDX_W = $clog2(TABLE_SIZE);

  // One output lane per destination tag value
  localparam int NUM_LANES = 1 << OUT_TAG_W;

  // --------------------------------------------------
  // Error reporting
  // --------------------------------------------------

  localparam int ERR_W = 16;

  // Nothing latched yet
  localparam logic [ERR_W-1:0] ERR_NONE = 16'h0000;

  // Two valid table entries share one source tag
  localparam logic [ERR_W-1:0] CFG_MAP_TAG_DUP_TAG = 16'h0001;

  // Valid input item hit no valid entry
  localparam logic [ERR_W-1:0] RT_MAP_TAG_NO_MATCH = 16'h0002;

  // --------------------------------------------------
  // Stream payloads
  // --------------------------------------------------

  // Item before translation
  typedef struct packed {
    logic [IN_TAG_W-1:0] tag;
    logic [DATA_W-1:0]   value;
  } in_item_t;

  // Item after translation
  typedef struct packed {
    logic [OUT_TAG_W-1:0] tag;
    logic [DATA_W-1:0]    value;
  } out_item_t;

  // --------------------------------------------------
  // Map table
  // --------------------------------------------------

  // One CAM entry, valid bit in the LSB
  typedef struct packed {
    logic [OUT_TAG_W-1:0] dst_tag;
    logic [IN_TAG_W-1:0]  src_tag;
    logic                 valid;
  } map_entry_t;

  // Whole table as seen by the mapper
  typedef map_entry_t [TABLE_SIZE-1:0] map_table_t;

endpackage
